/* rtl/cam_pkg.sv */
package cam_pkg;

  // ==========================================================
  // Data types
  // ==========================================================

  // Raw sensor sample
  typedef logic [11:0] raw_pix_t;

  // One serial byte
  typedef logic [7:0] byte_t;

  // Transmit word, seen as a pixel code or as two bytes
  typedef union packed {
    logic [15:0] code;
    struct packed {
      byte_t hi;
      byte_t lo;
    } bytes;
  } tx_word_u;

  // ==========================================================
  // Quantisation
  // ==========================================================

  // Strictly-above thresholds on the raw value
  localparam raw_pix_t THR_HIGH = 12'd127;
  localparam raw_pix_t THR_MID  = 12'd15;
  localparam raw_pix_t THR_LOW  = 12'd7;

  // ASCII digit pairs "33" "22" "11" "00"
  localparam logic [15:0] CODE_3 = 16'h3333;
  localparam logic [15:0] CODE_2 = 16'h3232;
  localparam logic [15:0] CODE_1 = 16'h3131;
  localparam logic [15:0] CODE_0 = 16'h3030;

endpackage

/* rtl/frame_capture.sv */
`timescale 1ns/1ps

module frame_capture #(
  parameter int IMG_SIDE = 28
) (
  input  logic                                  CLOCK_50,
  input  logic                                  KEY,
  input  logic                                  snap,
  input  logic                                  clear,
  input  cam_pkg::raw_pix_t                     cam_data,
  input  logic                                  cam_fval,
  input  logic                                  cam_lval,
  output logic                                  armed,
  output logic                                  wr_en,
  output logic [$clog2(IMG_SIDE*IMG_SIDE)-1:0]  wr_addr,
  output cam_pkg::raw_pix_t                     wr_data,
  output logic                                  img_done
);

  localparam int AW = $clog2(IMG_SIDE*IMG_SIDE);
  // Counters saturate at IMG_SIDE, so one extra code is needed
  localparam int CW = $clog2(IMG_SIDE+1);

  logic          fval_q;
  logic          lval_q;
  logic          capturing;
  logic [CW-1:0] col;
  logic [CW-1:0] line;
  logic [AW-1:0] wr_ptr;
  logic          pix_valid;
  logic          frame_start;
  logic          line_end;
  logic          in_win;
  logic          take;
  logic          last_pix;

  // ==========================================================
  // Strobe decode
  // ==========================================================
  assign pix_valid   = cam_fval & cam_lval;
  assign frame_start = cam_fval & ~fval_q;
  assign line_end    = lval_q & ~cam_lval;
  assign in_win      = (col < CW'(IMG_SIDE)) && (line < CW'(IMG_SIDE));

  // First pixel may share the cycle with the frame start
  assign take     = capturing | (frame_start & armed);
  assign wr_en    = take & pix_valid & in_win;
  assign wr_addr  = wr_ptr;
  assign wr_data  = cam_data;
  assign last_pix = wr_en && (col == CW'(IMG_SIDE-1)) && (line == CW'(IMG_SIDE-1));

  // ==========================================================
  // Arm and capture control
  // ==========================================================
  always_ff @(posedge CLOCK_50 or negedge KEY) begin
    if (!KEY) begin
      fval_q    <= 1'b0;
      lval_q    <= 1'b0;
      armed     <= 1'b0;
      capturing <= 1'b0;
      img_done  <= 1'b0;
    end else begin
      fval_q   <= cam_fval;
      lval_q   <= cam_lval;
      img_done <= last_pix;
      // Clear wins over snap; a starting frame uses up the arm
      if (clear) begin
        armed <= 1'b0;
      end else if (frame_start && armed) begin
        armed <= 1'b0;
      end else if (snap) begin
        armed <= 1'b1;
      end
      // Window complete or frame ended early
      if (last_pix || !cam_fval) begin
        capturing <= 1'b0;
      end else if (frame_start && armed) begin
        capturing <= 1'b1;
      end
    end
  end

  // ==========================================================
  // Column, line and address counters
  // ==========================================================
  always_ff @(posedge CLOCK_50 or negedge KEY) begin
    if (!KEY) begin
      col    <= '0;
      line   <= '0;
      wr_ptr <= '0;
    end else begin
      // Column restarts whenever the line strobe drops
      if (!cam_lval) begin
        col <= '0;
      end else if (pix_valid && col != CW'(IMG_SIDE)) begin
        col <= col + 1'b1;
      end
      // Line count advances at the end of each line
      if (!cam_fval) begin
        line <= '0;
      end else if (line_end && line != CW'(IMG_SIDE)) begin
        line <= line + 1'b1;
      end
      if (!cam_fval) begin
        wr_ptr <= '0;
      end else if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

endmodule

/* rtl/pixel_buffer.sv */
`timescale 1ns/1ps

module pixel_buffer #(
  parameter int IMG_SIDE = 28
) (
  input  logic                                  CLOCK_50,
  input  logic                                  wr_en,
  input  logic [$clog2(IMG_SIDE*IMG_SIDE)-1:0]  wr_addr,
  input  cam_pkg::raw_pix_t                     wr_data,
  input  logic                                  rd_en,
  input  logic [$clog2(IMG_SIDE*IMG_SIDE)-1:0]  rd_addr,
  output cam_pkg::raw_pix_t                     rd_data
);

  import cam_pkg::*;

  localparam int DEPTH = IMG_SIDE * IMG_SIDE;

  // One word per window pixel, row-major
  raw_pix_t mem [DEPTH];

  // Write port and registered read port
  always_ff @(posedge CLOCK_50) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

/* rtl/pixel_streamer.sv */
`timescale 1ns/1ps

module pixel_streamer #(
  parameter int IMG_SIDE = 28,
  parameter int TX_DEPTH = 4
) (
  input  logic                                  CLOCK_50,
  input  logic                                  KEY,
  input  logic                                  img_done,
  input  cam_pkg::raw_pix_t                     rd_data,
  input  logic                                  credit,
  output logic                                  rd_en,
  output logic [$clog2(IMG_SIDE*IMG_SIDE)-1:0]  rd_addr,
  output logic                                  word_valid,
  output cam_pkg::tx_word_u                     word,
  output logic                                  busy
);

  import cam_pkg::*;

  localparam int NPIX = IMG_SIDE * IMG_SIDE;
  localparam int AW   = $clog2(NPIX);
  localparam int CW   = $clog2(TX_DEPTH+1);

  logic          running;
  logic [AW-1:0] idx;
  logic          rd_pend;
  logic [CW-1:0] credit_cnt;

  // ==========================================================
  // Read issue
  // ==========================================================
  // A pending read already owns one of the credits
  assign rd_en   = running && (credit_cnt > CW'(rd_pend));
  assign rd_addr = idx;

  always_ff @(posedge CLOCK_50 or negedge KEY) begin
    if (!KEY) begin
      running <= 1'b0;
      idx     <= '0;
      rd_pend <= 1'b0;
    end else begin
      rd_pend <= rd_en;
      if (img_done) begin
        running <= 1'b1;
        idx     <= '0;
      end else if (rd_en) begin
        // Last pixel read ends the pass
        if (idx == AW'(NPIX-1)) begin
          running <= 1'b0;
        end
        idx <= idx + 1'b1;
      end
    end
  end

  // ==========================================================
  // Quantise and push
  // ==========================================================
  // Buffer data arrives the cycle after the read
  assign word_valid = rd_pend;

  always_comb begin
    if (rd_data > THR_HIGH) begin
      word.code = CODE_3;
    end else if (rd_data > THR_MID) begin
      word.code = CODE_2;
    end else if (rd_data > THR_LOW) begin
      word.code = CODE_1;
    end else begin
      word.code = CODE_0;
    end
  end

  // Credit count, spent on push and refilled by the transmitter
  always_ff @(posedge CLOCK_50 or negedge KEY) begin
    if (!KEY) begin
      credit_cnt <= CW'(TX_DEPTH);
    end else begin
      case ({word_valid, credit})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  // Busy until every word is out of the transmit FIFO
  assign busy = running | rd_pend | (credit_cnt != CW'(TX_DEPTH));

endmodule

/* rtl/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
  parameter int BAUD_DIV = 434,
  parameter int TX_DEPTH = 4
) (
  input  logic               CLOCK_50,
  input  logic               KEY,
  input  logic               word_valid,
  input  cam_pkg::tx_word_u  word,
  output logic               txd,
  output logic               credit
);

  import cam_pkg::*;

  localparam int PW = (TX_DEPTH > 1) ? $clog2(TX_DEPTH) : 1;
  localparam int CW = $clog2(TX_DEPTH+1);
  localparam int BW = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;

  tx_word_u      fifo [TX_DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  tx_word_u      head;

  logic [9:0]    shift;
  logic [3:0]    bit_cnt;
  logic [BW-1:0] baud_cnt;
  logic          active;
  logic          lo_pend;
  byte_t         lo_byte;
  logic          tick;
  logic          byte_end;
  logic          need_load;
  logic          load_lo;
  logic          pop;

  // ==========================================================
  // Word FIFO
  // ==========================================================
  assign head = fifo[rd_ptr];

  // Word storage, written on each push
  always_ff @(posedge CLOCK_50) begin
    if (word_valid) begin
      fifo[wr_ptr] <= word;
    end
  end

  always_ff @(posedge CLOCK_50 or negedge KEY) begin
    if (!KEY) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (word_valid) begin
        wr_ptr <= (wr_ptr == PW'(TX_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PW'(TX_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      end
      // Pushes never exceed the free slots thanks to credits
      count <= count + CW'(word_valid) - CW'(pop);
    end
  end

  // ==========================================================
  // Byte splitter and 8N1 shifter
  // ==========================================================
  assign tick      = active && (baud_cnt == BW'(BAUD_DIV-1));
  assign byte_end  = tick && (bit_cnt == 4'd9);
  // Next byte loads on the edge that ends the stop bit
  assign need_load = !active || byte_end;
  assign load_lo   = need_load && lo_pend;
  assign pop       = need_load && !lo_pend && (count != '0);
  assign credit    = pop;
  assign txd       = shift[0];

  always_ff @(posedge CLOCK_50 or negedge KEY) begin
    if (!KEY) begin
      shift    <= '1;
      bit_cnt  <= '0;
      baud_cnt <= '0;
      active   <= 1'b0;
      lo_pend  <= 1'b0;
      lo_byte  <= '0;
    end else if (pop) begin
      // High byte goes out first while the low byte waits
      shift    <= {1'b1, head.bytes.hi, 1'b0};
      lo_byte  <= head.bytes.lo;
      lo_pend  <= 1'b1;
      bit_cnt  <= '0;
      baud_cnt <= '0;
      active   <= 1'b1;
    end else if (load_lo) begin
      shift    <= {1'b1, lo_byte, 1'b0};
      lo_pend  <= 1'b0;
      bit_cnt  <= '0;
      baud_cnt <= '0;
      active   <= 1'b1;
    end else if (byte_end) begin
      // Line rests high with nothing queued
      active   <= 1'b0;
      shift    <= '1;
      baud_cnt <= '0;
    end else if (tick) begin
      shift    <= {1'b1, shift[9:1]};
      bit_cnt  <= bit_cnt + 1'b1;
      baud_cnt <= '0;
    end else if (active) begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

endmodule

/* rtl/cam_serial_top.sv */
`timescale 1ns/1ps

module cam_serial_top #(
  parameter int IMG_SIDE = 28,
  parameter int BAUD_DIV = 434,
  parameter int TX_DEPTH = 4
) (
  input  logic               CLOCK_50,
  input  logic               KEY,
  input  logic               snap,
  input  logic               clear,
  input  cam_pkg::raw_pix_t  cam_data,
  input  logic               cam_fval,
  input  logic               cam_lval,
  output logic               txd,
  output logic               armed,
  output logic               busy
);

  import cam_pkg::*;

  localparam int AW = $clog2(IMG_SIDE*IMG_SIDE);

  // Capture side
  logic          wr_en;
  logic [AW-1:0] wr_addr;
  raw_pix_t      wr_data;
  logic          img_done;

  // Readout side
  logic          rd_en;
  logic [AW-1:0] rd_addr;
  raw_pix_t      rd_data;

  // Credit loop to the transmitter
  logic          word_valid;
  tx_word_u      word;
  logic          credit;

  frame_capture #(.IMG_SIDE(IMG_SIDE)) u_capture (
    .CLOCK_50(CLOCK_50), .KEY(KEY), .snap(snap), .clear(clear),
    .cam_data(cam_data), .cam_fval(cam_fval), .cam_lval(cam_lval),
    .armed(armed), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .img_done(img_done)
  );

  pixel_buffer #(.IMG_SIDE(IMG_SIDE)) u_buffer (
    .CLOCK_50(CLOCK_50), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data)
  );

  pixel_streamer #(.IMG_SIDE(IMG_SIDE), .TX_DEPTH(TX_DEPTH)) u_streamer (
    .CLOCK_50(CLOCK_50), .KEY(KEY), .img_done(img_done), .rd_data(rd_data),
    .credit(credit), .rd_en(rd_en), .rd_addr(rd_addr),
    .word_valid(word_valid), .word(word), .busy(busy)
  );

  uart_tx #(.BAUD_DIV(BAUD_DIV), .TX_DEPTH(TX_DEPTH)) u_tx (
    .CLOCK_50(CLOCK_50), .KEY(KEY), .word_valid(word_valid), .word(word),
    .txd(txd), .credit(credit)
  );

endmodule

/* test/serial_monitor.sv */
`timescale 1ns/1ps

module serial_monitor #(
  parameter int BAUD_DIV = 4
) (
  input logic CLOCK_50,
  input logic KEY,
  input logic txd,
  input logic armed,
  input logic busy
);

  import cam_pkg::*;

  logic [15:0] exp_q [$];
  int          value_errs = 0;
  int          other_errs = 0;
  int          words_rx = 0;
  logic        have_hi = 1'b0;
  byte_t       hi_byte;

  // ==========================================================
  // Comparison helpers
  // ==========================================================
  task automatic expect_word(input logic [15:0] w);
    exp_q.push_back(w);
  endtask

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      value_errs++;
      $display("ERR %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic check_idle();
    compare_value("txd after reset", txd, 1);
    compare_value("armed after reset", armed, 0);
    compare_value("busy after reset", busy, 0);
  endtask

  task automatic check_armed(input logic exp);
    compare_value("armed", armed, exp);
  endtask

  // Line idle, nothing pending, total word count
  task automatic check_drained(input int total);
    if (exp_q.size() != 0) begin
      other_errs++;
      $display("%0d expected words never arrived on the serial line", exp_q.size());
      exp_q.delete();
    end
    if (have_hi) begin
      other_errs++;
      $display("a lone high byte was left without its low byte");
    end
    compare_value("words received", words_rx, total);
    compare_value("txd when idle", txd, 1);
    compare_value("busy when idle", busy, 0);
  endtask

  task automatic take_word(input logic [15:0] w);
    logic [15:0] exp;
    words_rx++;
    if (exp_q.size() == 0) begin
      other_errs++;
      $display("unexpected serial word %h at %0t ns", w, $time);
    end else begin
      exp = exp_q.pop_front();
      compare_value($sformatf("word %0d", words_rx - 1), w, exp);
    end
  endtask

  // ==========================================================
  // 8N1 receiver, mid-bit sampling on the falling edge
  // ==========================================================
  task automatic receive_byte();
    byte_t b;
    repeat (BAUD_DIV / 2) @(negedge CLOCK_50);
    if (txd !== 1'b0) begin
      other_errs++;
      $display("start bit ended early at %0t ns", $time);
      return;
    end
    for (int j = 0; j < 8; j++) begin
      repeat (BAUD_DIV) @(negedge CLOCK_50);
      b[j] = txd;
    end
    repeat (BAUD_DIV) @(negedge CLOCK_50);
    if (txd !== 1'b1) begin
      other_errs++;
      $display("stop bit was low at %0t ns", $time);
    end
    // High byte first
    if (!have_hi) begin
      hi_byte = b;
      have_hi = 1'b1;
    end else begin
      have_hi = 1'b0;
      take_word({hi_byte, b});
    end
  endtask

  always begin
    @(negedge CLOCK_50);
    if (KEY && txd === 1'b0) begin
      receive_byte();
    end
  end

endmodule

/* test/cam_serial_checker.sv */
`timescale 1ns/1ps

module cam_serial_checker #(
  parameter int TX_DEPTH = 4
) (
  input logic       CLOCK_50,
  input logic       KEY,
  input logic       word_valid,
  input logic       credit,
  input logic       txd,
  input logic       active,
  input logic [3:0] bit_cnt
);

  // Credits held by the streamer, mirrored from the handshake
  int held;
  int fail_count = 0;

  always_ff @(posedge CLOCK_50 or negedge KEY) begin
    if (!KEY) begin
      held <= TX_DEPTH;
    end else begin
      held <= held - int'(word_valid) + int'(credit);
    end
  end

  // ==========================================================
  // Properties
  // ==========================================================
  stop_bit_high: assert property (@(posedge CLOCK_50) disable iff (!KEY)
    (active && bit_cnt == 4'd9) |-> txd)
    else begin
      $error("stop bit driven low");
      fail_count++;
    end

  push_needs_credit: assert property (@(posedge CLOCK_50) disable iff (!KEY)
    word_valid |-> (held > 0))
    else begin
      $error("word pushed with no credit held");
      fail_count++;
    end

  // Never more credits back than words pushed
  credit_bounded: assert property (@(posedge CLOCK_50) disable iff (!KEY)
    credit |-> (held < TX_DEPTH))
    else begin
      $error("credit returned beyond the pushed words");
      fail_count++;
    end

endmodule

bind uart_tx cam_serial_checker #(.TX_DEPTH(TX_DEPTH)) u_checker (
  .CLOCK_50(CLOCK_50), .KEY(KEY), .word_valid(word_valid), .credit(credit),
  .txd(txd), .active(active), .bit_cnt(bit_cnt)
);

/* test/tb_cam_serial.sv */
`timescale 1ns/1ps

module tb_cam_serial;

  import cam_pkg::*;

  localparam int IMG_SIDE     = 28;
  localparam int BAUD_DIV     = 4;
  localparam int TX_DEPTH     = 4;
  localparam int NPIX         = IMG_SIDE * IMG_SIDE;
  localparam int FRAME_COLS   = 32;
  localparam int FRAME_LINES  = 30;
  localparam int LINE_GAP     = 4;
  localparam int TABLE_ROWS   = 2;
  // Lead-in, lines with gaps, tail
  localparam int FRAME_CYCLES = 3 + FRAME_LINES * (FRAME_COLS + LINE_GAP) + 4;
  localparam int N_FRAMES     = 4;
  localparam int N_IMAGES     = 2;
  // Two bytes of ten bits per pixel, plus slack for idle waits
  localparam int CYCLE_LIMIT  = N_FRAMES * FRAME_CYCLES
                              + N_IMAGES * 2 * NPIX * 10 * BAUD_DIV + 3000;

  logic     CLOCK_50;
  logic     KEY;
  logic     snap;
  logic     clear;
  raw_pix_t cam_data;
  logic     cam_fval;
  logic     cam_lval;
  logic     txd;
  logic     armed;
  logic     busy;

  raw_pix_t    img [NPIX];
  logic [15:0] exp_img [NPIX];
  logic [31:0] lcg_state = 32'd77247;
  int          cycles = 0;
  int          errors;

  // ==========================================================
  // Stimulus table, pixel and its code
  // ==========================================================
  raw_pix_t    tbl_pix [8] = '{12'd0, 12'd7, 12'd8, 12'd15,
                               12'd16, 12'd127, 12'd128, 12'd4095};
  logic [15:0] tbl_code [8] = '{"00", "00", "11", "11", "22", "22", "33", "33"};

  cam_serial_top #(.IMG_SIDE(IMG_SIDE), .BAUD_DIV(BAUD_DIV), .TX_DEPTH(TX_DEPTH)) UUT (
    .CLOCK_50(CLOCK_50), .KEY(KEY), .snap(snap), .clear(clear),
    .cam_data(cam_data), .cam_fval(cam_fval), .cam_lval(cam_lval),
    .txd(txd), .armed(armed), .busy(busy)
  );

  serial_monitor #(.BAUD_DIV(BAUD_DIV)) mon (
    .CLOCK_50(CLOCK_50), .KEY(KEY), .txd(txd), .armed(armed), .busy(busy)
  );

  initial begin
    CLOCK_50 = 1'b0;
    forever #5 CLOCK_50 = ~CLOCK_50;
  end

  // Run limit
  always @(posedge CLOCK_50) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("sim failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Strictly above 127, 15, 7
  function automatic logic [15:0] threshold_code(input raw_pix_t p);
    if (p > 12'd127) return "33";
    if (p > 12'd15) return "22";
    if (p > 12'd7) return "11";
    return "00";
  endfunction

  // ==========================================================
  // Image and frame tasks
  // ==========================================================
  task automatic fill_image(input bit use_table);
    logic [31:0] r;
    for (int i = 0; i < NPIX; i++) begin
      if (use_table && i < TABLE_ROWS * IMG_SIDE) begin
        img[i]     = tbl_pix[i % 8];
        exp_img[i] = tbl_code[i % 8];
      end else begin
        // Random shift spreads values over all four code bands
        r          = lcg_next();
        img[i]     = r[27:16] >> r[5:3];
        exp_img[i] = threshold_code(img[i]);
      end
    end
  endtask

  task automatic queue_expected();
    for (int i = 0; i < NPIX; i++) begin
      mon.expect_word(exp_img[i]);
    end
  endtask

  task automatic press_snap();
    @(negedge CLOCK_50);
    snap = 1'b1;
    @(negedge CLOCK_50);
    snap = 1'b0;
  endtask

  task automatic press_clear();
    @(negedge CLOCK_50);
    clear = 1'b1;
    @(negedge CLOCK_50);
    clear = 1'b0;
  endtask

  // 32 x 30 frame, window from img, the rest at full scale
  task automatic drive_frame();
    @(negedge CLOCK_50);
    cam_fval = 1'b1;
    repeat (2) @(negedge CLOCK_50);
    for (int ln = 0; ln < FRAME_LINES; ln++) begin
      for (int c = 0; c < FRAME_COLS; c++) begin
        cam_lval = 1'b1;
        if (ln < IMG_SIDE && c < IMG_SIDE) begin
          cam_data = img[ln * IMG_SIDE + c];
        end else begin
          cam_data = 12'hFFF;
        end
        @(negedge CLOCK_50);
      end
      cam_lval = 1'b0;
      cam_data = '0;
      repeat (LINE_GAP) @(negedge CLOCK_50);
    end
    cam_fval = 1'b0;
    repeat (4) @(negedge CLOCK_50);
  endtask

  task automatic wait_transfer();
    while (!busy) @(negedge CLOCK_50);
    while (busy) @(negedge CLOCK_50);
    // Last word still shifting out when busy drops
    repeat (3 * 10 * BAUD_DIV) @(negedge CLOCK_50);
  endtask

  // ==========================================================
  // Test sequence
  // ==========================================================
  initial begin
    KEY      = 1'b0;
    snap     = 1'b0;
    clear    = 1'b0;
    cam_data = '0;
    cam_fval = 1'b0;
    cam_lval = 1'b0;
    repeat (10) @(posedge CLOCK_50);
    @(negedge CLOCK_50);
    KEY = 1'b1;
    @(negedge CLOCK_50);
    mon.check_idle();

    // Unarmed frame, then an arm cancelled before the frame
    fill_image(1'b1);
    drive_frame();
    press_snap();
    mon.check_armed(1'b1);
    press_clear();
    mon.check_armed(1'b0);
    drive_frame();
    repeat (40 * BAUD_DIV) @(negedge CLOCK_50);
    mon.check_drained(0);

    // First capture, table rows then LCG pixels
    queue_expected();
    press_snap();
    drive_frame();
    wait_transfer();
    mon.check_drained(NPIX);

    // Second capture needs every credit back
    fill_image(1'b0);
    queue_expected();
    press_snap();
    mon.check_armed(1'b1);
    drive_frame();
    wait_transfer();
    mon.check_drained(2 * NPIX);

    errors = mon.value_errs + mon.other_errs + UUT.u_tx.u_checker.fail_count;
    $display("errors: %0d value, %0d other, %0d assertion, %0d words received",
             mon.value_errs, mon.other_errs, UUT.u_tx.u_checker.fail_count, mon.words_rx);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
rtl/cam_pkg.sv
rtl/frame_capture.sv
rtl/pixel_buffer.sv
rtl/pixel_streamer.sv
rtl/uart_tx.sv
rtl/cam_serial_top.sv
test/serial_monitor.sv
test/cam_serial_checker.sv
test/tb_cam_serial.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the camera serial testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module tb_cam_serial -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "sim passed" sim.log; then
  exit 0
fi
exit 1
